//--- src/quad_ctrl_pkg.sv
package quad_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Geometry widths and constants
    //////////////////////////////////////////////////////////////////////

    // Row, column and count fields
    localparam int DIM_W = 10;

    // Pixel-sequence BRAM address width
    localparam int PIX_ADDR_W = 12;

    typedef logic [DIM_W-1:0] dim_t;

    // 3x3 window needs three rows in the buffer before the first run
    localparam dim_t PRIME_ROWS = dim_t'(3);

    //////////////////////////////////////////////////////////////////////
    // Job configuration
    //////////////////////////////////////////////////////////////////////

    // Sampled at job accept, stable for the whole job
    typedef struct packed {
        dim_t num_input_rows;   // num_output_rows + 2 for a 3x3 window
        dim_t num_output_rows;
        dim_t row_words;        // Prefetch-buffer words per input row
        dim_t seq_len;          // Pixel-sequence reads per output row
    } layer_cfg_t;

    //////////////////////////////////////////////////////////////////////
    // Fetch handshake
    //////////////////////////////////////////////////////////////////////

    // Controller side
    typedef struct packed {
        logic request;
        logic in_progress;
    } fetch_req_t;

    // Fetch engine side
    typedef struct packed {
        logic ack;
        logic complete;
    } fetch_rsp_t;

    // Pixel-sequence BRAM read port
    typedef struct packed {
        logic                  rden;
        logic [PIX_ADDR_W-1:0] addr;
    } pix_seq_rd_t;

    // Job FSM states
    typedef enum logic [2:0] {
        ST_IDLE          = 3'd0,
        ST_PRIME         = 3'd1,
        ST_RUN           = 3'd2,
        ST_FETCH         = 3'd3,
        ST_WAIT_FLUSH    = 3'd4,
        ST_SEND_COMPLETE = 3'd5
    } ctrl_state_e;

endpackage

//--- src/quad_job_ctrl.sv
`timescale 1ns/1ps

module quad_job_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       job_start,
    input  quad_ctrl_pkg::layer_cfg_t  cfg,
    output logic                       job_accept,
    output logic                       fetch_go,
    input  logic                       fetch_done,
    output logic                       run_go,
    input  logic                       row_drained,
    input  logic                       pipeline_flushed,
    output logic                       job_complete,
    input  logic                       job_complete_ack,
    output logic [1:0]                 gray_code,
    output quad_ctrl_pkg::ctrl_state_e state
);
    import quad_ctrl_pkg::*;

    // Latched job geometry
    layer_cfg_t cfg_q;

    // Input rows fetched so far in this job
    dim_t in_rows;

    // Output rows drained so far in this job
    dim_t out_rows;

    // Binary bank count, shown as gray code
    logic [1:0] bank_cnt;

    logic last_out_row;

    //////////////////////////////////////////////////////////////////////
    // Row bookkeeping
    //////////////////////////////////////////////////////////////////////

    // Sequence 00, 01, 11, 10 from a plain 2-bit count
    assign gray_code = {bank_cnt[1], bank_cnt[1] ^ bank_cnt[0]};

    // Row now running is the last output row
    assign last_out_row = (out_rows == cfg_q.num_output_rows - dim_t'(1));

    // Geometry capture on accept
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && job_start) begin
            cfg_q <= cfg;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Job FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            job_accept   <= 1'b0;
            fetch_go     <= 1'b0;
            run_go       <= 1'b0;
            job_complete <= 1'b0;
            in_rows      <= '0;
            out_rows     <= '0;
            bank_cnt     <= 2'b00;
        end else begin
            // Single-cycle strobes
            job_accept <= 1'b0;
            fetch_go   <= 1'b0;
            run_go     <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        fetch_go   <= 1'b1;
                        in_rows    <= '0;
                        out_rows   <= '0;
                        bank_cnt   <= 2'b00;
                        state      <= ST_PRIME;
                    end
                end

                // Fill the buffer with the first window rows
                ST_PRIME: begin
                    if (fetch_done) begin
                        in_rows <= in_rows + dim_t'(1);
                        if (in_rows == PRIME_ROWS - dim_t'(1)) begin
                            run_go <= 1'b1;
                            state  <= ST_RUN;
                        end else begin
                            fetch_go <= 1'b1;
                        end
                    end
                end

                // One output row through the CE chain
                ST_RUN: begin
                    if (row_drained) begin
                        out_rows <= out_rows + dim_t'(1);
                        if (last_out_row) begin
                            bank_cnt <= 2'b00;
                            state    <= ST_WAIT_FLUSH;
                        end else begin
                            // Next bank, then the row below
                            bank_cnt <= bank_cnt + 2'b01;
                            fetch_go <= 1'b1;
                            state    <= ST_FETCH;
                        end
                    end
                end

                ST_FETCH: begin
                    if (fetch_done) begin
                        in_rows <= in_rows + dim_t'(1);
                        run_go  <= 1'b1;
                        state   <= ST_RUN;
                    end
                end

                ST_WAIT_FLUSH: begin
                    if (pipeline_flushed) begin
                        job_complete <= 1'b1;
                        state        <= ST_SEND_COMPLETE;
                    end
                end

                // Hold complete until acked
                ST_SEND_COMPLETE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- src/quad_row_fetch.sv
`timescale 1ns/1ps

module quad_row_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetch_go,
    input  quad_ctrl_pkg::dim_t       row_words,
    output quad_ctrl_pkg::fetch_req_t fetch_req,
    input  quad_ctrl_pkg::fetch_rsp_t fetch_rsp,
    output logic                      pfb_rden,
    output logic                      fetch_done
);
    import quad_ctrl_pkg::*;

    // Prefetch words still to read
    dim_t word_cnt;

    // Input column of the word being read
    dim_t in_col;

    logic last_word;
    logic fetch_cmpl;

    // Complete only counts while a fetch is in flight
    assign fetch_cmpl = fetch_req.in_progress && fetch_rsp.complete;

    assign pfb_rden  = (word_cnt != '0);
    assign last_word = (in_col == row_words - dim_t'(1));

    //////////////////////////////////////////////////////////////////////
    // Request / ack / complete
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_req <= '0;
        end else begin
            if (fetch_go) begin
                fetch_req.request <= 1'b1;
            end else if (fetch_req.request && fetch_rsp.ack) begin
                // Ack ends the request phase
                fetch_req.request     <= 1'b0;
                fetch_req.in_progress <= 1'b1;
            end else if (fetch_cmpl) begin
                fetch_req.in_progress <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Prefetch-buffer read burst
    //////////////////////////////////////////////////////////////////////

    // Loaded on complete, one word per cycle down to zero
    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt <= '0;
        end else if (fetch_cmpl) begin
            word_cnt <= row_words;
        end else if (pfb_rden) begin
            word_cnt <= word_cnt - dim_t'(1);
        end
    end

    // Column walk, done strobe after the last word
    always_ff @(posedge clk) begin
        if (rst) begin
            in_col     <= '0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            // Empty row finishes straight away
            if (fetch_cmpl && row_words == '0) begin
                fetch_done <= 1'b1;
            end
            if (pfb_rden) begin
                if (last_word) begin
                    in_col     <= '0;
                    fetch_done <= 1'b1;
                end else begin
                    in_col <= in_col + dim_t'(1);
                end
            end
        end
    end

endmodule

//--- src/quad_pix_seq.sv
`timescale 1ns/1ps

module quad_pix_seq (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       run_go,
    input  quad_ctrl_pkg::dim_t        seq_len,
    output quad_ctrl_pkg::pix_seq_rd_t pix_seq
);
    import quad_ctrl_pkg::*;

    // Reads left after the current one
    dim_t rd_left;

    //////////////////////////////////////////////////////////////////////
    // Sequence read generator
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_seq <= '0;
            rd_left <= '0;
        end else if (run_go) begin
            // First read in the cycle after the start strobe
            pix_seq.rden <= (seq_len != '0);
            pix_seq.addr <= '0;
            rd_left      <= seq_len - dim_t'(1);
        end else if (pix_seq.rden) begin
            if (rd_left == '0) begin
                // Sequence done, park the address at zero
                pix_seq.rden <= 1'b0;
                pix_seq.addr <= '0;
            end else begin
                rd_left      <= rd_left - dim_t'(1);
                pix_seq.addr <= pix_seq.addr + PIX_ADDR_W'(1);
            end
        end
    end

endmodule

//--- src/quad_ce_chain.sv
`timescale 1ns/1ps

module quad_ce_chain #(
    parameter int NUM_CE      = 8,
    parameter int SEQ_LATENCY = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              seq_rden,
    output logic [NUM_CE-1:0] ce_execute,
    output logic              row_drained
);

    // BRAM latency stages plus the engine stages
    localparam int CHAIN_LEN = SEQ_LATENCY + NUM_CE - 1;

    // Low taps model the read latency, high taps feed the engines
    logic [CHAIN_LEN-1:0] dly_q;

    // Last engine bit, one cycle old
    logic tail_q;

    //////////////////////////////////////////////////////////////////////
    // Latency delay and execute shift
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            dly_q <= '0;
        end else begin
            dly_q[0] <= seq_rden;
            for (int i = 1; i < CHAIN_LEN; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    // Engine k sees the read enable SEQ_LATENCY + k cycles late
    assign ce_execute = dly_q[CHAIN_LEN-1 -: NUM_CE];

    // Falling edge of the last engine marks the row as drained
    always_ff @(posedge clk) begin
        if (rst) begin
            tail_q <= 1'b0;
        end else begin
            tail_q <= ce_execute[NUM_CE-1];
        end
    end

    assign row_drained = tail_q && !ce_execute[NUM_CE-1];

endmodule

//--- src/quad_bram_ctrl.sv
`timescale 1ns/1ps

module quad_bram_ctrl #(
    parameter int NUM_CE      = 8,
    parameter int SEQ_LATENCY = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    input  quad_ctrl_pkg::layer_cfg_t  cfg,
    input  logic                       job_start,
    output logic                       job_accept,
    output quad_ctrl_pkg::fetch_req_t  fetch_req,
    input  quad_ctrl_pkg::fetch_rsp_t  fetch_rsp,
    output logic                       pfb_rden,
    output quad_ctrl_pkg::pix_seq_rd_t pix_seq,
    output logic [NUM_CE-1:0]          ce_execute,
    output logic [1:0]                 gray_code,
    input  logic                       pipeline_flushed,
    output logic                       job_complete,
    input  logic                       job_complete_ack,
    output quad_ctrl_pkg::ctrl_state_e state
);

    // Stage strobes
    logic fetch_go;
    logic fetch_done;
    logic run_go;
    logic row_drained;

    //////////////////////////////////////////////////////////////////////
    // Job sequencing
    //////////////////////////////////////////////////////////////////////

    quad_job_ctrl quad_job_ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .cfg              (cfg),
        .job_accept       (job_accept),
        .fetch_go         (fetch_go),
        .fetch_done       (fetch_done),
        .run_go           (run_go),
        .row_drained      (row_drained),
        .pipeline_flushed (pipeline_flushed),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .gray_code        (gray_code),
        .state            (state)
    );

    // cfg is stable during the job, so the stages read it directly
    quad_row_fetch quad_row_fetch_i (
        .clk        (clk),
        .rst        (rst),
        .fetch_go   (fetch_go),
        .row_words  (cfg.row_words),
        .fetch_req  (fetch_req),
        .fetch_rsp  (fetch_rsp),
        .pfb_rden   (pfb_rden),
        .fetch_done (fetch_done)
    );

    //////////////////////////////////////////////////////////////////////
    // Output row execution
    //////////////////////////////////////////////////////////////////////

    quad_pix_seq quad_pix_seq_i (
        .clk     (clk),
        .rst     (rst),
        .run_go  (run_go),
        .seq_len (cfg.seq_len),
        .pix_seq (pix_seq)
    );

    quad_ce_chain #(
        .NUM_CE      (NUM_CE),
        .SEQ_LATENCY (SEQ_LATENCY)
    ) quad_ce_chain_i (
        .clk         (clk),
        .rst         (rst),
        .seq_rden    (pix_seq.rden),
        .ce_execute  (ce_execute),
        .row_drained (row_drained)
    );

endmodule

//--- tb/quad_bram_ctrl_tb.sv
`timescale 1ns/1ps

module quad_bram_ctrl_tb;
    import quad_ctrl_pkg::*;

    localparam int NUM_CE       = 8;
    localparam int SEQ_LATENCY  = 3;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int HIST_W       = SEQ_LATENCY + NUM_CE;

    // Two job shapes, input rows always two above output rows
    localparam layer_cfg_t CFG_A = '{num_input_rows: 10'd6, num_output_rows: 10'd4,
                                     row_words: 10'd5, seq_len: 10'd6};
    localparam layer_cfg_t CFG_B = '{num_input_rows: 10'd8, num_output_rows: 10'd6,
                                     row_words: 10'd3, seq_len: 10'd11};

    logic              clk = 1'b0;
    logic              rst;
    layer_cfg_t        cfg;
    logic              job_start;
    logic              job_accept;
    fetch_req_t        fetch_req;
    fetch_rsp_t        fetch_rsp;
    logic              pfb_rden;
    pix_seq_rd_t       pix_seq;
    logic [NUM_CE-1:0] ce_execute;
    logic [1:0]        gray_code;
    logic              pipeline_flushed;
    logic              job_complete;
    logic              job_complete_ack;
    ctrl_state_e       state;

    integer seed = 32'h9521_1fee;
    int     error_cnt = 0;
    int     check_cnt = 0;

    // Running totals kept by the cycle monitor
    int fetch_cnt = 0;
    int run_cnt = 0;
    int accept_cnt = 0;
    int complete_cnt = 0;

    quad_bram_ctrl #(
        .NUM_CE      (NUM_CE),
        .SEQ_LATENCY (SEQ_LATENCY)
    ) quad_bram_ctrl_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_state(input ctrl_state_e exp, input ctrl_state_e act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("error at %0d ns: state expected %s, actual %s",
                     $time, exp.name(), act.name());
        end
    endtask

    task automatic check_fetch(input fetch_req_t exp, input fetch_req_t act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("error at %0d ns: fetch_req expected req=%b busy=%b, actual req=%b busy=%b",
                     $time, exp.request, exp.in_progress, act.request, act.in_progress);
        end
    endtask

    task automatic check_seq(input pix_seq_rd_t exp, input pix_seq_rd_t act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("error at %0d ns: pix_seq expected rden=%b addr=%0d, actual rden=%b addr=%0d",
                     $time, exp.rden, exp.addr, act.rden, act.addr);
        end
    endtask

    task automatic check_bits(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("error at %0d ns: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    // Per-job event totals
    task automatic check_count(input string name, input int exp, input int act);
        check_cnt++;
        if (act != exp) begin
            error_cnt++;
            $display("error at %0d ns: %s expected %0d, actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        error_cnt++;
        $display("At %0d ns the DUT failed: %s", $time, msg);
    endtask

    // Bank order 00, 01, 11, 10
    function automatic logic [1:0] gray_step(input int step);
        case (step % 4)
            0: return 2'b00;
            1: return 2'b01;
            2: return 2'b11;
            default: return 2'b10;
        endcase
    endfunction

    function automatic int random_delay(input int max_cycles);
        return {$random(seed)} % (max_cycles + 1);
    endfunction

    // Worst case, fetches plus rows plus the job handshakes
    function automatic int job_cycle_bound(input layer_cfg_t c);
        int fetch_cycles;
        int row_cycles;
        fetch_cycles = int'(c.num_input_rows) * (int'(c.row_words) + 16);
        row_cycles = int'(c.num_output_rows) * (int'(c.seq_len) + SEQ_LATENCY + NUM_CE + 4);
        return fetch_cycles + row_cycles + 28;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Responders for the fetch engine, flush and complete ack
    //////////////////////////////////////////////////////////////////////

    task automatic respond_fetch();
        forever begin
            @(negedge clk);
            if (fetch_req.request) begin
                repeat (random_delay(3)) @(posedge clk);
                @(posedge clk);
                #1 fetch_rsp.ack = 1'b1;
                @(posedge clk);
                #1 fetch_rsp.ack = 1'b0;
                // Remote transfer time
                repeat (random_delay(5)) @(posedge clk);
                @(posedge clk);
                #1 fetch_rsp.complete = 1'b1;
                @(posedge clk);
                #1 fetch_rsp.complete = 1'b0;
            end
        end
    endtask

    task automatic respond_flush();
        forever begin
            @(negedge clk);
            if (state == ST_WAIT_FLUSH) begin
                repeat (random_delay(7)) @(posedge clk);
                @(posedge clk);
                #1 pipeline_flushed = 1'b1;
                @(negedge clk);
                while (state == ST_WAIT_FLUSH) @(negedge clk);
                @(posedge clk);
                #1 pipeline_flushed = 1'b0;
            end
        end
    endtask

    task automatic respond_complete_ack();
        forever begin
            @(negedge clk);
            if (job_complete) begin
                repeat (random_delay(3)) @(posedge clk);
                @(posedge clk);
                #1 job_complete_ack = 1'b1;
                @(negedge clk);
                while (job_complete) @(negedge clk);
                @(posedge clk);
                #1 job_complete_ack = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Cycle monitor with reference models
    //////////////////////////////////////////////////////////////////////

    task automatic monitor_cycles();
        logic [HIST_W-1:0] hist;
        logic [NUM_CE-1:0] exp_ce;
        pix_seq_rd_t       exp_seq;
        fetch_req_t        exp_fetch;
        fetch_req_t        prev_req;
        ctrl_state_e       prev_state;
        logic              have_exp_fetch;
        logic              prev_complete;
        logic              prev_flushed;
        logic              prev_cack;
        int                seq_left;
        int                seq_addr;
        int                pfb_left;
        int                row_idx;
        hist = '0;
        prev_req = '0;
        prev_state = ST_IDLE;
        have_exp_fetch = 1'b0;
        prev_complete = 1'b0;
        prev_flushed = 1'b0;
        prev_cack = 1'b0;
        seq_left = 0;
        seq_addr = 0;
        pfb_left = 0;
        row_idx = 0;
        forever begin
            @(negedge clk);
            // Execute bits against a shift register of rden history
            hist = {hist[HIST_W-2:0], pix_seq.rden};
            for (int k = 0; k < NUM_CE; k++) begin
                exp_ce[k] = hist[SEQ_LATENCY+k];
            end
            check_bits("ce_execute", 32'(exp_ce), 32'(ce_execute));
            exp_seq.rden = (seq_left != 0);
            exp_seq.addr = exp_seq.rden ? 12'(seq_addr) : '0;
            check_seq(exp_seq, pix_seq);
            if (seq_left != 0) begin
                seq_left--;
                seq_addr++;
            end
            // Fetch handshake
            if (have_exp_fetch) begin
                check_fetch(exp_fetch, fetch_req);
            end
            if (fetch_req.request && !prev_req.request) begin
                fetch_cnt++;
                if (prev_req.in_progress || pfb_left != 0) begin
                    report_failure("fetch request raised again before the row was read");
                end
            end
            check_bits("pfb_rden", 32'(pfb_left != 0), 32'(pfb_rden));
            if (pfb_left != 0) begin
                pfb_left--;
            end
            if (fetch_req.in_progress && fetch_rsp.complete) begin
                pfb_left = int'(cfg.row_words);
            end
            have_exp_fetch = 1'b1;
            exp_fetch.request = 1'b0;
            exp_fetch.in_progress = 1'b0;
            if (fetch_req.request && fetch_rsp.ack) begin
                exp_fetch.in_progress = 1'b1;
            end else if (fetch_req.in_progress) begin
                exp_fetch.in_progress = !fetch_rsp.complete;
            end else if (fetch_req.request) begin
                exp_fetch.request = 1'b1;
            end else begin
                // Idle, a new request may start
                have_exp_fetch = 1'b0;
            end
            // Row bookkeeping from state changes
            if (state != prev_state) begin
                if (prev_state == ST_IDLE) begin
                    row_idx = 0;
                end
                if (prev_state == ST_RUN) begin
                    run_cnt++;
                    row_idx = (state == ST_FETCH) ? row_idx + 1 : 0;
                    if (seq_left != 0) begin
                        report_failure("run ended before all pixel reads were issued");
                    end
                end
                if (state == ST_RUN) begin
                    seq_left = int'(cfg.seq_len);
                    seq_addr = 0;
                end
            end
            check_bits("gray_code", 32'(gray_step(row_idx)), 32'(gray_code));
            // Job handshakes
            if (job_accept) begin
                accept_cnt++;
            end
            if (job_complete && !prev_complete) begin
                complete_cnt++;
                if (!prev_flushed || prev_state != ST_WAIT_FLUSH) begin
                    report_failure("job_complete rose without pipeline_flushed");
                end
            end
            if (!job_complete && prev_complete) begin
                if (!prev_cack) begin
                    report_failure("job_complete dropped before it was acknowledged");
                end
                check_state(ST_IDLE, state);
            end
            prev_req = fetch_req;
            prev_state = state;
            prev_complete = job_complete;
            prev_flushed = pipeline_flushed;
            prev_cack = job_complete_ack;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        repeat (3) begin
            @(negedge clk);
            check_state(ST_IDLE, state);
            check_fetch('0, fetch_req);
            check_seq('0, pix_seq);
            check_bits("job_accept", 0, 32'(job_accept));
            check_bits("pfb_rden", 0, 32'(pfb_rden));
            check_bits("ce_execute", 0, 32'(ce_execute));
            check_bits("gray_code", 0, 32'(gray_code));
            check_bits("job_complete", 0, 32'(job_complete));
        end
    endtask

    // One full job from start to complete ack
    task automatic test_job(input layer_cfg_t job_cfg);
        int fetch_base;
        int run_base;
        int accept_base;
        int complete_base;
        @(posedge clk);
        #1;
        fetch_base = fetch_cnt;
        run_base = run_cnt;
        accept_base = accept_cnt;
        complete_base = complete_cnt;
        cfg = job_cfg;
        job_start = 1'b1;
        @(negedge clk);
        check_bits("job_accept", 0, 32'(job_accept));
        // Accept lands one cycle after start is seen
        @(negedge clk);
        check_bits("job_accept", 1, 32'(job_accept));
        check_state(ST_PRIME, state);
        @(posedge clk);
        #1 job_start = 1'b0;
        @(negedge clk);
        while (!job_complete) @(negedge clk);
        while (job_complete) @(negedge clk);
        check_state(ST_IDLE, state);
        check_bits("gray_code", 0, 32'(gray_code));
        @(posedge clk);
        #1;
        check_count("job accepts", 1, accept_cnt - accept_base);
        check_count("fetches", int'(job_cfg.num_input_rows), fetch_cnt - fetch_base);
        check_count("output rows", int'(job_cfg.num_output_rows), run_cnt - run_base);
        check_count("job completes", 1, complete_cnt - complete_base);
    endtask

    initial begin
        rst = 1'b1;
        job_start = 1'b0;
        cfg = '0;
        fetch_rsp = '0;
        pipeline_flushed = 1'b0;
        job_complete_ack = 1'b0;
        fork
            respond_fetch();
            respond_flush();
            respond_complete_ack();
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        fork
            monitor_cycles();
        join_none
        test_reset_values();
        test_job(CFG_A);
        test_job(CFG_B);
        $display("%0d checks, %0d errors", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = 4 * (RESET_CYCLES + 8 + job_cycle_bound(CFG_A) + job_cycle_bound(CFG_B));
        repeat (limit) @(posedge clk);
        $display("Timeout: tests still running after %0d clock cycles", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- filelist.f
src/quad_ctrl_pkg.sv
src/quad_job_ctrl.sv
src/quad_row_fetch.sv
src/quad_pix_seq.sv
src/quad_ce_chain.sv
src/quad_bram_ctrl.sv
tb/quad_bram_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= quad_bram_ctrl_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
